//--- Makefile
VERILATOR  := verilator
TOP        := pipe_cpu_tb
FILELIST   := pipe_cpu.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/pipe_cpu_assert.sv
// port-level rules for pipe_cpu, sampled on rising clk and ignored while reset is high
`timescale 1ns/1ps

module pipe_cpu_assert (
  input logic        clk,
  input logic        reset,
  input logic [31:0] imem_addr,
  input logic        dmem_read,
  input logic        dmem_write,
  input logic        is_halted
);

  int failures = 0;  // tallied for the end-of-run summary

  no_read_with_write: assert property (@(posedge clk) disable iff (reset)
    !(dmem_read && dmem_write))
    else begin
      failures++;
      $error("dmem_read and dmem_write were high in the same cycle");
    end

  // halt is a level that only reset clears
  halt_is_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted)
    else begin
      failures++;
      $error("is_halted dropped without a reset");
    end

  no_store_when_halted: assert property (@(posedge clk) disable iff (reset)
    is_halted |-> !dmem_write)
    else begin
      failures++;
      $error("a store reached dmem while the core was halted");
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (reset)
    imem_addr[1:0] == 2'b00)
    else begin
      failures++;
      $error("imem_addr is not word aligned");
    end

endmodule

bind pipe_cpu pipe_cpu_assert props_i (
  .clk(clk), .reset(reset), .imem_addr(imem_addr), .dmem_read(dmem_read),
  .dmem_write(dmem_write), .is_halted(is_halted)
);

//--- bench/pipe_cpu_tb.sv
// 8-word programs from a table, imem past the program reads as zero (no-op), dmem is 16 words
`timescale 1ns/1ps

module pipe_cpu_tb;

  localparam int period_ns    = 40;
  localparam int reset_cycles = 8;
  localparam int run_limit    = 60;
  localparam int settle       = 4;  // cycles watched after halt for stray stores
  localparam int num_rows     = 7;
  localparam int prog_words   = 8;
  localparam longint watchdog_ns = num_rows * (run_limit + reset_cycles) * period_ns + 5000;

  localparam logic [31:0] ecall_w = 32'h0000_0073;
  localparam logic [31:0] nop_w   = 32'h0000_0013;  // addi x0,x0,0

  logic clk, reset;
  logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic dmem_read, dmem_write, is_halted;

  logic [31:0] imem [prog_words];
  logic [31:0] dmem [16];
  logic [31:0] store_addr_log [$];
  logic [31:0] store_data_log [$];

  string       row_name   [num_rows];
  logic [31:0] row_prog   [num_rows][prog_words];
  int          row_stores [num_rows];
  logic [31:0] row_addr   [num_rows];
  logic [31:0] row_data   [num_rows];
  logic        row_halt   [num_rows];

  int errors = 0;
  int checks = 0;
  int assert_fails;

  pipe_cpu dut_i (
    .clk, .reset, .imem_addr, .imem_rdata, .dmem_addr, .dmem_wdata,
    .dmem_read, .dmem_write, .dmem_rdata, .is_halted
  );

  always #(period_ns / 2) clk = ~clk;

  assign imem_rdata = (imem_addr < 32'(prog_words * 4)) ? imem[imem_addr[4:2]] : '0;
  assign dmem_rdata = dmem_read ? dmem[dmem_addr[5:2]] : '0;  // data only while a load reads

  // dmem write port and in-order store log
  always @(posedge clk) begin
    if (reset) begin
      for (int a = 0; a < 16; a++) dmem[a] <= '0;
      store_addr_log.delete();
      store_data_log.delete();
    end else if (dmem_write) begin
      dmem[dmem_addr[5:2]] <= dmem_wdata;
      store_addr_log.push_back(dmem_addr);
      store_data_log.push_back(dmem_wdata);
    end
  end

  // rv32i base format encoders
  function automatic logic [31:0] rop(input int f7, input int f3, input int rd,
                                      input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                         input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic set_row(input int r, input string name, input int stores,
                         input logic [31:0] addr, input logic [31:0] data, input logic halt);
    row_name[r]   = name;
    row_stores[r] = stores;
    row_addr[r]   = addr;
    row_data[r]   = data;
    row_halt[r]   = halt;
  endtask

  // name, stores, last store address and data, halt expected
  task automatic build_table();
    row_prog[0] = '{addi(1, 0, 5), addi(2, 0, 7), rop(0, 0, 3, 1, 2), rop(32, 0, 4, 3, 1),
                    sw(4, 0, 4), addi(17, 0, 10), ecall_w, nop_w};
    set_row(0, "alu_chain", 1, 32'd4, 32'd7, 1'b1);
    row_prog[1] = '{addi(1, 0, 9), sw(1, 0, 0), lw(2, 0, 0), rop(0, 0, 3, 2, 2),
                    sw(3, 0, 8), addi(17, 0, 10), ecall_w, nop_w};
    set_row(1, "load_use", 2, 32'd8, 32'd18, 1'b1);
    row_prog[2] = '{addi(1, 0, 3), branch(0, 1, 1, 8), addi(1, 1, 1), sw(1, 0, 12),
                    addi(17, 0, 10), ecall_w, nop_w, nop_w};
    set_row(2, "beq_taken", 1, 32'd12, 32'd3, 1'b1);  // addi skipped
    row_prog[3] = '{addi(1, 0, 3), branch(1, 1, 1, 8), addi(1, 1, 1), sw(1, 0, 12),
                    addi(17, 0, 10), ecall_w, nop_w, nop_w};
    set_row(3, "bne_fallthrough", 1, 32'd12, 32'd4, 1'b1);
    row_prog[4] = '{addi(6, 0, 1), jal(5, 12), sw(6, 0, 20), sw(6, 0, 24), sw(5, 0, 28),
                    addi(17, 0, 10), ecall_w, nop_w};
    set_row(4, "jal_link", 1, 32'd28, 32'd8, 1'b1);  // link is 4 + 4
    row_prog[5] = '{addi(17, 0, 3), ecall_w, addi(1, 0, 21), sw(1, 0, 32),
                    addi(17, 0, 10), ecall_w, sw(1, 0, 36), nop_w};
    set_row(5, "ecall_codes", 1, 32'd32, 32'd21, 1'b1);
    // and, or, xor, slt on a negative operand, then an add
    row_prog[6] = '{addi(1, 0, -4), addi(2, 0, 6), rop(0, 7, 3, 1, 2), rop(0, 6, 4, 3, 2),
                    rop(0, 4, 5, 4, 1), rop(0, 2, 6, 5, 2), rop(0, 0, 7, 6, 5), sw(7, 0, 40)};
    set_row(6, "logic_no_halt", 1, 32'd40, 32'hffff_fffb, 1'b0);
  endtask

  task automatic run_row(input int r);
    int w;
    int cycles;
    @(posedge clk);
    reset <= 1'b1;
    for (w = 0; w < prog_words; w++) imem[w] <= row_prog[r][w];
    repeat (reset_cycles) @(negedge clk);
    check_value({row_name[r], " reset imem_addr"}, 32'h0, imem_addr);
    check_value({row_name[r], " reset dmem_write"}, 32'h0, 32'(dmem_write));
    check_value({row_name[r], " reset dmem_read"}, 32'h0, 32'(dmem_read));
    check_value({row_name[r], " reset is_halted"}, 32'h0, 32'(is_halted));
    @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    while (!is_halted && cycles < run_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (is_halted) repeat (settle) @(negedge clk);
    check_value({row_name[r], " halted"}, 32'(row_halt[r]), 32'(is_halted));
    check_value({row_name[r], " store count"}, row_stores[r], store_addr_log.size());
    if (store_addr_log.size() > 0) begin
      check_value({row_name[r], " last store addr"}, row_addr[r], store_addr_log[$]);
      check_value({row_name[r], " last store data"}, row_data[r], store_data_log[$]);
    end
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    build_table();
    for (int r = 0; r < num_rows; r++) run_row(r);
    assert_fails = dut_i.props_i.failures;
    $display("errors: %0d, assertion failures: %0d, checks: %0d", errors, assert_fails, checks);
    if (errors == 0 && assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog sized from the rows and the per-row cycle budget
  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("sim failed");
    $finish;
  end

endmodule

//--- pipe_cpu.f
source/cpu_pkg.sv
source/pipe_if.sv
source/fetch_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_writeback.sv
source/halt_control.sv
source/pipe_cpu.sv
bench/pipe_cpu_assert.sv
bench/pipe_cpu_tb.sv

//--- source/cpu_pkg.sv
// RV32I subset only (no shifts, byte/half loads, LUI/AUIPC or JALR); encodings follow the base ISA
package cpu_pkg;

  localparam int xlen         = 32;
  localparam int reg_idx_bits = 5;

  // major opcodes
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add = 3'b000; // also sub, told apart by funct7
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  localparam logic [6:0] f7_sub = 7'b0100000;

  // alu operation codes, decode to execute
  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_xor = 3'd4;
  localparam logic [2:0] alu_slt = 3'd5;

  localparam logic [reg_idx_bits-1:0] reg_a7 = 5'd17; // ecall argument register

  // one instruction word, seen through each encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_t;

endpackage

//--- source/decode_stage.sv
// decoder, register file and ID/EX; unsupported opcodes decode as no-ops, x0 reads as zero
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  inst_t                   if_inst,
  input  logic [xlen-1:0]         if_pc,
  flow_if.follower                flow,
  fwd_if.regwrite                 wb,
  output logic [xlen-1:0]         id_pc,
  output logic [xlen-1:0]         id_rs1_val,
  output logic [xlen-1:0]         id_rs2_val,
  output logic [xlen-1:0]         id_imm,
  output logic [reg_idx_bits-1:0] id_rs1,
  output logic [reg_idx_bits-1:0] id_rs2,
  output logic [reg_idx_bits-1:0] id_rd,
  output logic [2:0]              id_alu_op,
  output logic                    id_use_imm,
  output logic                    id_is_load,
  output logic                    id_is_store,
  output logic                    id_is_branch,
  output logic                    id_branch_ne,
  output logic                    id_is_jal,
  output logic                    id_is_ecall,
  output logic                    id_reg_write
);

  logic [xlen-1:0] regs [32];
  logic [reg_idx_bits-1:0] rs1, rs2, rd;
  logic [xlen-1:0] imm;
  logic [2:0] alu_op;
  logic use_imm, is_load, is_store, is_branch, branch_ne, is_jal, is_ecall, reg_write;
  logic bubble;

  // write-before-read, a same-cycle writeback is visible
  function automatic logic [xlen-1:0] read_reg(input logic [reg_idx_bits-1:0] idx);
    if (idx == '0) return '0;
    if (wb.wb_reg_write && wb.wb_rd == idx) return wb.wb_value;
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (wb.wb_reg_write && wb.wb_rd != '0) regs[wb.wb_rd] <= wb.wb_value;
  end

  always_comb begin
    rs1 = '0; rs2 = '0; rd = '0;  // unused sources stay 0, no false hazard
    imm = '0;
    alu_op = alu_add;
    {use_imm, is_load, is_store, is_branch, branch_ne, is_jal, is_ecall, reg_write} = '0;
    case (if_inst.r.opcode)
      op_rtype: begin
        rs1 = if_inst.r.rs1;
        rs2 = if_inst.r.rs2;
        rd = if_inst.r.rd;
        reg_write = 1'b1;
        case (if_inst.r.funct3)
          f3_add: alu_op = (if_inst.r.funct7 == f7_sub) ? alu_sub : alu_add;
          f3_slt: alu_op = alu_slt;
          f3_xor: alu_op = alu_xor;
          f3_or:  alu_op = alu_or;
          f3_and: alu_op = alu_and;
          default: reg_write = 1'b0;
        endcase
      end
      op_itype, op_load: begin  // addi, lw
        rs1 = if_inst.i.rs1;
        rd = if_inst.i.rd;
        imm = {{20{if_inst.i.imm[11]}}, if_inst.i.imm};
        use_imm = 1'b1;
        is_load = (if_inst.i.opcode == op_load);
        reg_write = 1'b1;
      end
      op_store: begin
        rs1 = if_inst.s.rs1;
        rs2 = if_inst.s.rs2;
        imm = {{20{if_inst.s.imm_hi[6]}}, if_inst.s.imm_hi, if_inst.s.imm_lo};
        use_imm = 1'b1;
        is_store = 1'b1;
      end
      op_branch: begin
        rs1 = if_inst.b.rs1;
        rs2 = if_inst.b.rs2;
        imm = {{19{if_inst.b.imm12}}, if_inst.b.imm12, if_inst.b.imm11,
               if_inst.b.imm10_5, if_inst.b.imm4_1, 1'b0};
        is_branch = (if_inst.b.funct3 == f3_beq) || (if_inst.b.funct3 == f3_bne);
        branch_ne = (if_inst.b.funct3 == f3_bne);
      end
      op_jal: begin
        rd = if_inst.j.rd;
        imm = {{11{if_inst.j.imm20}}, if_inst.j.imm20, if_inst.j.imm19_12,
               if_inst.j.imm11, if_inst.j.imm10_1, 1'b0};
        is_jal = 1'b1;
        reg_write = 1'b1;
      end
      op_system: begin
        is_ecall = (if_inst.i.imm == '0);  // ebreak ignored
        rs1 = is_ecall ? reg_a7 : '0;
      end
      default: ;
    endcase
    if (!reg_write) rd = '0;
  end

  // load in EX feeding this instruction
  assign flow.stall = id_is_load && id_rd != '0 && (id_rd == rs1 || id_rd == rs2);
  assign bubble = reset || flow.stall || flow.redirect || flow.freeze;

  always_ff @(posedge clk) begin
    if (bubble) begin
      {id_is_load, id_is_store, id_is_branch, id_is_jal, id_is_ecall, id_reg_write} <= '0;
      id_rs1 <= '0;
      id_rs2 <= '0;
      id_rd  <= '0;
    end else begin
      {id_is_load, id_is_store, id_is_branch, id_is_jal, id_is_ecall, id_reg_write} <=
        {is_load, is_store, is_branch, is_jal, is_ecall, reg_write};
      id_rs1 <= rs1;
      id_rs2 <= rs2;
      id_rd  <= rd;
    end
  end

  always_ff @(posedge clk) begin
    id_pc <= if_pc;
    id_rs1_val <= read_reg(rs1);
    id_rs2_val <= read_reg(rs2);
    id_imm <= imm;
    id_alu_op <= alu_op;
    id_use_imm <= use_imm;
    id_branch_ne <= branch_ne;
  end

endmodule

//--- source/execute_stage.sv
// forwarding, alu, branch/jal resolution and EX/MEM; not-taken is the only prediction
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [xlen-1:0]         id_pc,
  input  logic [xlen-1:0]         id_rs1_val,
  input  logic [xlen-1:0]         id_rs2_val,
  input  logic [xlen-1:0]         id_imm,
  input  logic [reg_idx_bits-1:0] id_rs1,
  input  logic [reg_idx_bits-1:0] id_rs2,
  input  logic [reg_idx_bits-1:0] id_rd,
  input  logic [2:0]              id_alu_op,
  input  logic                    id_use_imm,
  input  logic                    id_is_load,
  input  logic                    id_is_store,
  input  logic                    id_is_branch,
  input  logic                    id_branch_ne,
  input  logic                    id_is_jal,
  input  logic                    id_is_ecall,
  input  logic                    id_reg_write,
  fwd_if.producer                 fwd,
  fwd_if.consumer                 fwd_in,
  flow_if.steer                   flow,
  output logic                    ecall,
  output logic [xlen-1:0]         ecall_value,
  output logic [xlen-1:0]         ex_alu_out,
  output logic [xlen-1:0]         ex_store_data,
  output logic                    ex_is_load,
  output logic                    ex_is_store
);

  logic [xlen-1:0] op_a, op_b, rs2_fwd, alu_res;
  logic [reg_idx_bits-1:0] ex_rd;
  logic ex_reg_write;
  logic taken;

  // newest producer wins, x0 never forwarded
  function automatic logic [xlen-1:0] pick(input logic [reg_idx_bits-1:0] idx,
                                           input logic [xlen-1:0] reg_val);
    if (idx == '0) return reg_val;
    if (fwd_in.mem_reg_write && !fwd_in.mem_is_load && fwd_in.mem_rd == idx)
      return fwd_in.mem_value;
    if (fwd_in.wb_reg_write && fwd_in.wb_rd == idx) return fwd_in.wb_value;
    return reg_val;
  endfunction

  assign op_a    = pick(id_rs1, id_rs1_val);
  assign rs2_fwd = pick(id_rs2, id_rs2_val);
  assign op_b    = id_use_imm ? id_imm : rs2_fwd;

  always_comb begin
    case (id_alu_op)
      alu_sub: alu_res = op_a - op_b;
      alu_and: alu_res = op_a & op_b;
      alu_or:  alu_res = op_a | op_b;
      alu_xor: alu_res = op_a ^ op_b;
      alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_res = op_a + op_b;
    endcase
  end

  assign taken = id_is_branch && ((op_a == rs2_fwd) != id_branch_ne);
  assign flow.redirect    = taken || id_is_jal;   // flushes IF and ID
  assign flow.redirect_pc = id_pc + id_imm;

  assign ecall       = id_is_ecall;
  assign ecall_value = op_a;  // rs1 forced to a7 in decode

  always_ff @(posedge clk) begin
    if (reset) begin
      {ex_is_load, ex_is_store, ex_reg_write} <= '0;
      ex_rd <= '0;
    end else begin
      {ex_is_load, ex_is_store, ex_reg_write} <= {id_is_load, id_is_store, id_reg_write};
      ex_rd <= id_rd;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_out    <= id_is_jal ? id_pc + xlen'(4) : alu_res;  // link value for jal
    ex_store_data <= rs2_fwd;
  end

  assign fwd.mem_rd        = ex_rd;
  assign fwd.mem_reg_write = ex_reg_write;
  assign fwd.mem_value     = ex_alu_out;
  assign fwd.mem_is_load   = ex_is_load;

endmodule

//--- source/fetch_unit.sv
// pc and IF/ID; assumes word-aligned targets and an imem that answers in the same cycle
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            reset,
  flow_if.follower        flow,
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_rdata,
  output inst_t           if_inst,
  output logic [xlen-1:0] if_pc
);

  logic [xlen-1:0] pc;

  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else if (flow.redirect) begin
      pc <= flow.redirect_pc;  // wins over stall
    end else if (flow.stall || flow.freeze) begin
      pc <= pc;
    end else begin
      pc <= pc + xlen'(4);
    end
  end

  // IF/ID, an all-zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (reset || flow.redirect) begin
      if_inst <= '0;
    end else if (!(flow.stall || flow.freeze)) begin
      if_inst <= imem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!(flow.stall || flow.freeze)) if_pc <= pc;  // pc only matters with a live inst
  end

endmodule

//--- source/halt_control.sv
// halts on ecall with a7 == halt_code after a fixed 3-cycle drain; only reset leaves halted
`timescale 1ns/1ps

module halt_control import cpu_pkg::*; #(
  parameter logic [xlen-1:0] halt_code = 10
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            ecall,
  input  logic [xlen-1:0] ecall_value,
  flow_if.hold            flow,
  output logic            is_halted
);

  localparam logic [1:0] st_running  = 2'd0;
  localparam logic [1:0] st_draining = 2'd1;
  localparam logic [1:0] st_halted   = 2'd2;

  logic [1:0] state;
  logic [1:0] drain_cnt;
  logic hit;

  assign hit = ecall && (ecall_value == halt_code);  // other values are a no-op

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_running;
      drain_cnt <= '0;
    end else begin
      case (state)
        st_running:  if (hit) state <= st_draining;
        st_draining: begin
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == 2'd2) state <= st_halted;  // MEM and WB retired
        end
        default: state <= st_halted;
      endcase
    end
  end

  // freeze already in the ecall cycle so nothing younger gets in
  assign flow.freeze = (state != st_running) || hit;
  assign is_halted   = (state == st_halted);

endmodule

//--- source/mem_writeback.sv
// drives the data port straight from EX/MEM; dmem must return read data in the same cycle
`timescale 1ns/1ps

module mem_writeback import cpu_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] ex_alu_out,
  input  logic [xlen-1:0] ex_store_data,
  input  logic            ex_is_load,
  input  logic            ex_is_store,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic            dmem_read,
  output logic            dmem_write,
  input  logic [xlen-1:0] dmem_rdata,
  fwd_if.producer_wb      wb
);

  logic [xlen-1:0] mw_rdata, mw_alu;
  logic mw_load;

  assign dmem_addr  = ex_alu_out;
  assign dmem_wdata = ex_store_data;
  assign dmem_read  = ex_is_load;
  assign dmem_write = ex_is_store;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb.wb_reg_write <= 1'b0;
      wb.wb_rd <= '0;
    end else begin
      wb.wb_reg_write <= wb.mem_reg_write;
      wb.wb_rd <= wb.mem_rd;
    end
  end

  always_ff @(posedge clk) begin
    mw_load  <= ex_is_load;
    mw_rdata <= dmem_rdata;
    mw_alu   <= ex_alu_out;
  end

  assign wb.wb_value = mw_load ? mw_rdata : mw_alu;  // writeback select

endmodule

//--- source/pipe_cpu.sv
// five-stage rv32i subset core; imem and dmem live outside and must answer combinationally
`timescale 1ns/1ps

module pipe_cpu import cpu_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc  = '0,
  parameter logic [xlen-1:0] halt_code = 10
) (
  input  logic            clk,
  input  logic            reset,
  output logic [xlen-1:0] imem_addr,
  input  logic [xlen-1:0] imem_rdata,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic            dmem_read,
  output logic            dmem_write,
  input  logic [xlen-1:0] dmem_rdata,
  output logic            is_halted
);

  fwd_if  fwd ();
  flow_if flow ();

  inst_t if_inst;
  logic [xlen-1:0] if_pc;
  logic [xlen-1:0] id_pc, id_rs1_val, id_rs2_val, id_imm;
  logic [reg_idx_bits-1:0] id_rs1, id_rs2, id_rd;
  logic [2:0] id_alu_op;
  logic id_use_imm, id_is_load, id_is_store, id_is_branch, id_branch_ne;
  logic id_is_jal, id_is_ecall, id_reg_write;
  logic [xlen-1:0] ex_alu_out, ex_store_data, ecall_value;
  logic ex_is_load, ex_is_store, ecall;

  fetch_unit #(.reset_pc(reset_pc)) u_fetch (
    .clk, .reset, .flow(flow.follower), .imem_addr, .imem_rdata, .if_inst, .if_pc
  );

  decode_stage u_decode (
    .clk, .reset, .if_inst, .if_pc, .flow(flow.follower), .wb(fwd.regwrite),
    .id_pc, .id_rs1_val, .id_rs2_val, .id_imm, .id_rs1, .id_rs2, .id_rd, .id_alu_op,
    .id_use_imm, .id_is_load, .id_is_store, .id_is_branch, .id_branch_ne, .id_is_jal,
    .id_is_ecall, .id_reg_write
  );

  execute_stage u_execute (
    .clk, .reset, .id_pc, .id_rs1_val, .id_rs2_val, .id_imm, .id_rs1, .id_rs2, .id_rd,
    .id_alu_op, .id_use_imm, .id_is_load, .id_is_store, .id_is_branch, .id_branch_ne,
    .id_is_jal, .id_is_ecall, .id_reg_write,
    .fwd(fwd.producer), .fwd_in(fwd.consumer), .flow(flow.steer),
    .ecall, .ecall_value, .ex_alu_out, .ex_store_data, .ex_is_load, .ex_is_store
  );

  mem_writeback u_memwb (
    .clk, .reset, .ex_alu_out, .ex_store_data, .ex_is_load, .ex_is_store,
    .dmem_addr, .dmem_wdata, .dmem_read, .dmem_write, .dmem_rdata, .wb(fwd.producer_wb)
  );

  halt_control #(.halt_code(halt_code)) u_halt (
    .clk, .reset, .ecall, .ecall_value, .flow(flow.hold), .is_halted
  );

endmodule

//--- source/pipe_if.sv
// all members are plain levels with no handshake; sampled on the rising edge of clk
`timescale 1ns/1ps

// forwarding sources and the register write port
interface fwd_if import cpu_pkg::*; ();
  logic [reg_idx_bits-1:0] mem_rd;
  logic                    mem_reg_write;
  logic [xlen-1:0]         mem_value;
  logic                    mem_is_load;   // mem_value is an address, data not back yet
  logic [reg_idx_bits-1:0] wb_rd;
  logic                    wb_reg_write;
  logic [xlen-1:0]         wb_value;

  modport producer (output mem_rd, mem_reg_write, mem_value, mem_is_load);
  modport producer_wb (input mem_rd, mem_reg_write, output wb_rd, wb_reg_write, wb_value);
  modport consumer (input mem_rd, mem_reg_write, mem_value, mem_is_load,
                    input wb_rd, wb_reg_write, wb_value);
  modport regwrite (input wb_rd, wb_reg_write, wb_value);
endinterface

// fetch steering
interface flow_if import cpu_pkg::*; ();
  logic            stall;        // load-use, from decode
  logic            redirect;     // taken branch or jal, from execute
  logic [xlen-1:0] redirect_pc;
  logic            freeze;       // halt in progress

  modport follower (output stall, input redirect, redirect_pc, freeze);
  modport steer (output redirect, redirect_pc);
  modport hold (output freeze);
endinterface
